//--- hdl/app_worker.sv
`timescale 1ns/1ns

module app_worker (
   input  logic                           clk,
   input  logic                           ap_rst_n,
   input  logic                           ap_start,
   input  swarm_task_pkg::task_t          task_in,

   output logic                           ap_done,
   output logic                           ap_idle,

   output logic                           task_out_valid,
   output swarm_task_pkg::task_t          task_out_data,
   input  logic                           task_out_ready,

   output logic                           app_undo_valid,
   output swarm_task_pkg::undo_log_addr_t app_undo_addr,
   output swarm_task_pkg::undo_log_data_t app_undo_data,
   input  logic                           app_undo_ready
);
import swarm_task_pkg::*;

logic       busy;
logic [7:0] child_idx;

// Child k writes the word child_arg + k and logs child_arg as its old value
function automatic task_t child_of(task_t parent, logic [7:0] k);
   task_t child;
   child.ts    = parent.ts + (ts_t'(k) + 1) * ts_t'(parent.args.spawn.ts_delta);
   child.ttype = TT_WRITE;
   child.hint  = parent.hint + hint_t'(k);
   child.args.wr.addr     = parent.args.spawn.child_arg + undo_log_addr_t'(k);
   child.args.wr.old_data = parent.args.spawn.child_arg;
   return child;
endfunction

assign ap_idle       = !busy;
assign task_out_data = child_of(task_in, child_idx);
assign app_undo_addr = task_in.args.wr.addr;
assign app_undo_data = task_in.args.wr.old_data;

always_ff @(posedge clk) begin
   if (!ap_rst_n) begin
      busy           <= 1'b0;
      ap_done        <= 1'b0;
      task_out_valid <= 1'b0;
      app_undo_valid <= 1'b0;
      child_idx      <= '0;
   end else begin
      ap_done <= 1'b0;
      if (ap_start & !busy) begin
         busy      <= 1'b1;
         child_idx <= '0;
         if ((task_in.ttype == TT_SPAWN) && (task_in.args.spawn.n_children != '0)) begin
            task_out_valid <= 1'b1;
         end else if (task_in.ttype == TT_WRITE) begin
            app_undo_valid <= 1'b1;
         end else begin
            // Nothing to do for this task
            busy    <= 1'b0;
            ap_done <= 1'b1;
         end
      end
      if (task_out_valid & task_out_ready) begin
         if (child_idx + 8'd1 == task_in.args.spawn.n_children) begin
            task_out_valid <= 1'b0;
            busy           <= 1'b0;
            ap_done        <= 1'b1;
         end else begin
            child_idx <= child_idx + 8'd1;
         end
      end
      if (app_undo_valid & app_undo_ready) begin
         app_undo_valid <= 1'b0;
         busy           <= 1'b0;
         ap_done        <= 1'b1;
      end
   end
end

endmodule

//--- hdl/core_out_buf.sv
`timescale 1ns/1ns

module core_out_buf (
   input  logic                           clk,
   input  logic                           rstn,

   input  logic                           task_out_valid,
   input  swarm_task_pkg::task_t          task_out_data,
   output logic                           task_out_ready,
   output logic                           task_wvalid,
   output swarm_task_pkg::task_t          task_wdata,
   input  logic                           task_wready,

   input  logic                           app_undo_valid,
   input  swarm_task_pkg::undo_log_addr_t app_undo_addr,
   input  swarm_task_pkg::undo_log_data_t app_undo_data,
   output logic                           app_undo_ready,
   output logic                           undo_log_valid,
   output swarm_task_pkg::undo_id_t       undo_log_id,
   output swarm_task_pkg::undo_log_addr_t undo_log_addr,
   output swarm_task_pkg::undo_log_data_t undo_log_data,
   input  logic                           undo_log_ready,

   input  logic                           drop_enq,
   input  logic                           task_done,

   output logic                           enq_fire,
   output logic                           undo_fire,
   output logic                           out_busy
);

// Refill only when empty, so a stalled record stalls the worker
assign task_out_ready = !task_wvalid;
assign app_undo_ready = !undo_log_valid;

assign enq_fire  = task_wvalid & task_wready;
assign undo_fire = undo_log_valid & undo_log_ready;
assign out_busy  = task_wvalid | undo_log_valid;

always_ff @(posedge clk) begin
   if (!rstn) begin
      task_wvalid <= 1'b0;
   end else if (task_out_valid & task_out_ready) begin
      task_wvalid <= 1'b1;
   end else if (task_wready | drop_enq) begin
      task_wvalid <= 1'b0;
   end
end

always_ff @(posedge clk) begin
   if (task_out_valid & task_out_ready) begin
      task_wdata <= task_out_data;
   end
end

always_ff @(posedge clk) begin
   if (!rstn) begin
      undo_log_valid <= 1'b0;
   end else if (app_undo_valid & app_undo_ready) begin
      undo_log_valid <= 1'b1;
   end else if (undo_log_ready) begin
      undo_log_valid <= 1'b0;
   end
end

always_ff @(posedge clk) begin
   if (app_undo_valid & app_undo_ready) begin
      undo_log_addr <= app_undo_addr;
      undo_log_data <= app_undo_data;
   end
end

// Id of the record on the output, restarts for every task
always_ff @(posedge clk) begin
   if (!rstn) begin
      undo_log_id <= '0;
   end else if (task_done) begin
      undo_log_id <= '0;
   end else if (undo_fire) begin
      undo_log_id <= undo_log_id + 1'b1;
   end
end

endmodule

//--- hdl/core_reg_pkg.sv
package core_reg_pkg;

localparam logic [7:0] CORE_START      = 8'h00;
localparam logic [7:0] CORE_N_DEQUEUES = 8'h04;
localparam logic [7:0] CORE_NUM_ENQ    = 8'h08;
localparam logic [7:0] CORE_NUM_DEQ    = 8'h0c;
localparam logic [7:0] CORE_STATE      = 8'h10;
localparam logic [7:0] CORE_TS         = 8'h14;

typedef enum logic [2:0] {
   NEXT_TASK,
   INFORM_CQ,
   START_CORE,
   WAIT_CORE,
   ABORT_TASK,
   FINISH_TASK
} core_state_t;

endpackage

//--- hdl/core_regs.sv
`timescale 1ns/1ns

module core_regs #(
   parameter int CORE_ID = 0
) (
   input  logic                      clk,
   input  logic                      rstn,

   input  logic                      reg_wvalid,
   input  logic [7:0]                reg_waddr,
   input  logic [31:0]               reg_wdata,
   input  logic                      reg_arvalid,
   input  logic [7:0]                reg_araddr,
   output logic                      reg_rvalid,
   output logic [31:0]               reg_rdata,

   input  logic                      deq_fire,
   input  logic                      enq_fire,
   input  core_reg_pkg::core_state_t state,
   input  swarm_task_pkg::ts_t       task_ts,

   output logic                      core_start,
   output logic                      budget_nonzero
);
import core_reg_pkg::*;

logic [31:0] dequeues_remaining;
logic [31:0] num_enqueues;
logic [31:0] num_dequeues;

assign budget_nonzero = (dequeues_remaining != '0);

always_ff @(posedge clk) begin
   if (!rstn) begin
      core_start <= 1'b0;
   end else if (reg_wvalid && (reg_waddr == CORE_START)) begin
      core_start <= reg_wdata[CORE_ID];
   end
end

// A write of the budget wins over a dequeue in the same cycle
always_ff @(posedge clk) begin
   if (!rstn) begin
      dequeues_remaining <= '1;
   end else if (reg_wvalid && (reg_waddr == CORE_N_DEQUEUES)) begin
      dequeues_remaining <= reg_wdata;
   end else if (deq_fire) begin
      dequeues_remaining <= dequeues_remaining - 1'b1;
   end
end

always_ff @(posedge clk) begin
   if (!rstn) begin
      num_enqueues <= '0;
      num_dequeues <= '0;
   end else begin
      if (enq_fire) begin
         num_enqueues <= num_enqueues + 1'b1;
      end
      if (deq_fire) begin
         num_dequeues <= num_dequeues + 1'b1;
      end
   end
end

always_ff @(posedge clk) begin
   if (!rstn) begin
      reg_rvalid <= 1'b0;
   end else begin
      reg_rvalid <= reg_arvalid;
   end
end

always_ff @(posedge clk) begin
   if (reg_arvalid) begin
      case (reg_araddr)
         CORE_START:      reg_rdata <= 32'(core_start) << CORE_ID;
         CORE_N_DEQUEUES: reg_rdata <= dequeues_remaining;
         CORE_NUM_ENQ:    reg_rdata <= num_enqueues;
         CORE_NUM_DEQ:    reg_rdata <= num_dequeues;
         CORE_STATE:      reg_rdata <= 32'(state);
         CORE_TS:         reg_rdata <= task_ts;
         default:         reg_rdata <= '0;
      endcase
   end
end

endmodule

//--- hdl/swarm_core.sv
`timescale 1ns/1ns

module swarm_core #(
   parameter int CORE_ID    = 0,
   parameter int ABORT_HOLD = 4
) (
   input  logic                           clk,
   input  logic                           rstn,

   output logic                           task_arvalid,
   input  logic                           task_rvalid,
   input  swarm_task_pkg::task_t          task_rdata,
   input  swarm_task_pkg::cq_slice_slot_t task_rslot,

   output logic                           task_wvalid,
   output swarm_task_pkg::task_t          task_wdata,
   input  logic                           task_wready,
   output logic                           task_enq_untied,

   output logic                           start_task_valid,
   input  logic                           start_task_ready,
   output swarm_task_pkg::cq_slice_slot_t start_task_slot,

   output logic                           finish_task_valid,
   input  logic                           finish_task_ready,
   output swarm_task_pkg::cq_slice_slot_t finish_task_slot,
   output swarm_task_pkg::child_id_t      finish_task_num_children,
   output logic                           finish_task_undo_log_write,

   input  logic                           abort_running_task,
   input  logic                           gvt_task_slot_valid,
   input  swarm_task_pkg::cq_slice_slot_t gvt_task_slot,

   output logic                           undo_log_valid,
   input  logic                           undo_log_ready,
   output swarm_task_pkg::undo_id_t       undo_log_id,
   output swarm_task_pkg::undo_log_addr_t undo_log_addr,
   output swarm_task_pkg::undo_log_data_t undo_log_data,

   input  logic                           reg_wvalid,
   input  logic [7:0]                     reg_waddr,
   input  logic [31:0]                    reg_wdata,
   input  logic                           reg_arvalid,
   input  logic [7:0]                     reg_araddr,
   output logic                           reg_rvalid,
   output logic [31:0]                    reg_rdata
);
import swarm_task_pkg::*;
import core_reg_pkg::*;

task_t          task_in;
core_state_t    state;
logic           core_start;
logic           budget_nonzero;
logic           ap_start;
logic           ap_rst_n;
logic           ap_done;
logic           ap_idle;
logic           task_out_valid;
task_t          task_out_data;
logic           task_out_ready;
logic           app_undo_valid;
undo_log_addr_t app_undo_addr;
undo_log_data_t app_undo_data;
logic           app_undo_ready;
logic           enq_fire;
logic           undo_fire;
logic           out_busy;

task_core_ctrl #(
   .ABORT_HOLD (ABORT_HOLD)
) ctrl0 (
   .*
);

app_worker worker0 (
   .*
);

core_out_buf obuf0 (
   .drop_enq  (state == ABORT_TASK),
   .task_done (finish_task_valid),
   .*
);

core_regs #(
   .CORE_ID (CORE_ID)
) regs0 (
   .deq_fire (task_arvalid & task_rvalid),
   .task_ts  (task_in.ts),
   .*
);

endmodule

//--- hdl/swarm_task_pkg.sv
package swarm_task_pkg;

typedef logic [31:0] ts_t;
typedef logic [15:0] hint_t;
typedef logic [3:0]  task_type_t;

localparam task_type_t TT_SPAWN = 4'd0;
localparam task_type_t TT_WRITE = 4'd1;

typedef logic [5:0]  cq_slice_slot_t;
typedef logic [3:0]  child_id_t;
typedef logic [3:0]  undo_id_t;
typedef logic [31:0] undo_log_addr_t;
typedef logic [31:0] undo_log_data_t;

// Spawn view of the argument word
typedef struct packed {
   logic [7:0]  n_children;
   logic [23:0] ts_delta;
   logic [31:0] child_arg;
} spawn_args_t;

// Write view, the old value is what the undo log restores
typedef struct packed {
   undo_log_addr_t addr;
   undo_log_data_t old_data;
} write_args_t;

typedef union packed {
   spawn_args_t spawn;
   write_args_t wr;
} task_args_u;

typedef struct packed {
   task_args_u args;
   task_type_t ttype;
   hint_t      hint;
   ts_t        ts;
} task_t;

endpackage

//--- hdl/task_core_ctrl.sv
`timescale 1ns/1ns

module task_core_ctrl #(
   parameter int ABORT_HOLD = 4
) (
   input  logic                           clk,
   input  logic                           rstn,

   output logic                           task_arvalid,
   input  logic                           task_rvalid,
   input  swarm_task_pkg::task_t          task_rdata,
   input  swarm_task_pkg::cq_slice_slot_t task_rslot,

   input  logic                           core_start,
   input  logic                           budget_nonzero,
   output swarm_task_pkg::task_t          task_in,

   output logic                           start_task_valid,
   input  logic                           start_task_ready,
   output swarm_task_pkg::cq_slice_slot_t start_task_slot,

   output logic                           finish_task_valid,
   input  logic                           finish_task_ready,
   output swarm_task_pkg::cq_slice_slot_t finish_task_slot,
   output swarm_task_pkg::child_id_t      finish_task_num_children,
   output logic                           finish_task_undo_log_write,

   input  logic                           abort_running_task,

   input  logic                           gvt_task_slot_valid,
   input  swarm_task_pkg::cq_slice_slot_t gvt_task_slot,
   output logic                           task_enq_untied,

   output logic                           ap_start,
   output logic                           ap_rst_n,
   input  logic                           ap_done,
   input  logic                           ap_idle,

   input  logic                           enq_fire,
   input  logic                           undo_fire,
   input  logic                           out_busy,

   output core_reg_pkg::core_state_t      state
);
import swarm_task_pkg::*;
import core_reg_pkg::*;

localparam int HOLD_W = $clog2(ABORT_HOLD + 1);

core_state_t       state_next;
cq_slice_slot_t    cq_slot;
child_id_t         child_cnt;
logic              abort_q;
logic [HOLD_W-1:0] hold_cnt;
logic              deq_fire;

assign task_arvalid = (state == NEXT_TASK) & core_start & budget_nonzero;
assign deq_fire     = task_arvalid & task_rvalid;

assign start_task_valid = (state == INFORM_CQ);
assign start_task_slot  = cq_slot;

// Both output registers must drain before the CQ sees the finish
assign finish_task_valid        = (state == FINISH_TASK) & !out_busy;
assign finish_task_slot         = cq_slot;
assign finish_task_num_children = child_cnt;

assign ap_start = (state == START_CORE) & !abort_q;

always_ff @(posedge clk) begin
   if (deq_fire) begin
      cq_slot <= task_rslot;
      task_in <= task_rdata;
   end
end

always_ff @(posedge clk) begin
   if (!rstn) begin
      abort_q <= 1'b0;
   end else if (state == NEXT_TASK) begin
      abort_q <= 1'b0;
   end else if (abort_running_task) begin
      abort_q <= 1'b1;
   end
end

always_ff @(posedge clk) begin
   if (!rstn) begin
      task_enq_untied <= 1'b0;
   end else begin
      task_enq_untied <= gvt_task_slot_valid & (gvt_task_slot == cq_slot);
   end
end

// Children sent after the task became untied get no cut-tie message
always_ff @(posedge clk) begin
   if (!rstn) begin
      child_cnt                  <= '0;
      finish_task_undo_log_write <= 1'b0;
   end else if (deq_fire) begin
      child_cnt                  <= '0;
      finish_task_undo_log_write <= 1'b0;
   end else begin
      if (enq_fire & !task_enq_untied) begin
         child_cnt <= child_cnt + 1'b1;
      end
      if (undo_fire) begin
         finish_task_undo_log_write <= 1'b1;
      end
   end
end

// Abort of a running worker is a timed reset
always_ff @(posedge clk) begin
   if (!rstn) begin
      hold_cnt <= '0;
      ap_rst_n <= 1'b0;
   end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
      ap_rst_n <= (hold_cnt == HOLD_W'(1));
   end else if ((state == WAIT_CORE) & abort_q & !ap_done) begin
      hold_cnt <= HOLD_W'(ABORT_HOLD);
      ap_rst_n <= 1'b0;
   end else begin
      ap_rst_n <= 1'b1;
   end
end

always_comb begin
   state_next = state;
   case (state)
      NEXT_TASK: begin
         if (deq_fire) begin
            state_next = INFORM_CQ;
         end
      end
      INFORM_CQ: begin
         if (start_task_ready) begin
            state_next = abort_q ? FINISH_TASK : START_CORE;
         end
      end
      START_CORE: begin
         state_next = abort_q ? FINISH_TASK : WAIT_CORE;
      end
      WAIT_CORE: begin
         // ap_done is ignored once the hold has begun
         if (hold_cnt == HOLD_W'(1)) begin
            state_next = ABORT_TASK;
         end else if ((hold_cnt == '0) & ap_done) begin
            state_next = FINISH_TASK;
         end
      end
      ABORT_TASK: begin
         if (ap_idle) begin
            state_next = FINISH_TASK;
         end
      end
      FINISH_TASK: begin
         if (finish_task_valid & finish_task_ready) begin
            state_next = NEXT_TASK;
         end
      end
      default: begin
         state_next = NEXT_TASK;
      end
   endcase
end

always_ff @(posedge clk) begin
   if (!rstn) begin
      state <= NEXT_TASK;
   end else begin
      state <= state_next;
   end
end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the swarm_core testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_swarm_core \
   -f swarm_core.f -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
fi

if grep -q "TEST PASSED" sim.log; then
   exit 0
fi
exit 1

//--- swarm_core.f
hdl/swarm_task_pkg.sv
hdl/core_reg_pkg.sv
hdl/task_core_ctrl.sv
hdl/app_worker.sv
hdl/core_out_buf.sv
hdl/core_regs.sv
hdl/swarm_core.sv
testbench/tb_swarm_core.sv

//--- testbench/tb_swarm_core.sv
`timescale 1ns/1ns

module tb_swarm_core;
import swarm_task_pkg::*;
import core_reg_pkg::*;

localparam int CORE_ID    = 0;
localparam int ABORT_HOLD = 4;
localparam int N_ROWS     = 6;

logic           clk;
logic           rstn;
logic           task_arvalid;
logic           task_rvalid;
task_t          task_rdata;
cq_slice_slot_t task_rslot;
logic           task_wvalid;
task_t          task_wdata;
logic           task_wready;
logic           task_enq_untied;
logic           start_task_valid;
logic           start_task_ready;
cq_slice_slot_t start_task_slot;
logic           finish_task_valid;
logic           finish_task_ready;
cq_slice_slot_t finish_task_slot;
child_id_t      finish_task_num_children;
logic           finish_task_undo_log_write;
logic           abort_running_task;
logic           gvt_task_slot_valid;
cq_slice_slot_t gvt_task_slot;
logic           undo_log_valid;
logic           undo_log_ready;
undo_id_t       undo_log_id;
undo_log_addr_t undo_log_addr;
undo_log_data_t undo_log_data;
logic           reg_wvalid;
logic [7:0]     reg_waddr;
logic [31:0]    reg_wdata;
logic           reg_arvalid;
logic [7:0]     reg_araddr;
logic           reg_rvalid;
logic [31:0]    reg_rdata;

// Spawn args are {n_children, ts_delta, child_arg} and write args {addr, old_data}
task_type_t     tab_type   [N_ROWS] = '{TT_SPAWN, TT_WRITE, TT_SPAWN, TT_SPAWN, TT_SPAWN,
                                         TT_WRITE};
logic [63:0]    tab_args   [N_ROWS] = '{{8'd3, 24'd5, 32'h0000_1000},
                                         {32'h2000_0040, 32'hdead_beef},
                                         {8'd4, 24'd7, 32'h0000_3000},
                                         {8'd14, 24'd2, 32'h0000_4000},
                                         {8'd2, 24'd9, 32'h0000_5000},
                                         {32'h2000_0080, 32'h1234_5678}};
cq_slice_slot_t tab_slot   [N_ROWS] = '{6'd3, 6'd7, 6'd12, 6'd20, 6'd21, 6'd33};
int             tab_abort  [N_ROWS] = '{0, 0, 0, 3, 0, 0};
logic           tab_gvt    [N_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
child_id_t      tab_nchild [N_ROWS] = '{4'd3, 4'd0, 4'd0, 4'd0, 4'd2, 4'd0};
logic           tab_undo   [N_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1};

logic [31:0]    lfsr = 32'h485b;
task_t          got_enq [$];
int             enq_beats;
int             undo_n;
undo_id_t       got_undo_id;
undo_log_addr_t got_undo_addr;
undo_log_data_t got_undo_data;
logic           fin_seen;
cq_slice_slot_t got_fin_slot;
child_id_t      got_fin_children;
logic           got_fin_undo;
logic           got_fin_untied;
logic           abort_seen;
int             abort_left;
cq_slice_slot_t cur_slot;

swarm_core #(
   .CORE_ID    (CORE_ID),
   .ABORT_HOLD (ABORT_HOLD)
) dut0 (
   .*
);

initial begin
   clk = 1'b0;
   forever #5 clk = ~clk;
end

function automatic logic next_rand_bit();
   logic fb;
   fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
   lfsr = {lfsr[30:0], fb};
   return lfsr[0];
endfunction

task automatic stop_run();
   $display("TEST FAILED");
   $fatal(1, "simulation stopped at first failure");
endtask

task automatic report_timeout(string what);
   $display("timeout while waiting for %s at %0t", what, $time);
   stop_run();
endtask

task automatic check_task(string name, task_t got, task_t exp);
   if (got !== exp) begin
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_run();
   end
endtask

task automatic check_slot(string name, cq_slice_slot_t got, cq_slice_slot_t exp);
   if (got !== exp) begin
      $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
      stop_run();
   end
endtask

task automatic check_child(string name, child_id_t got, child_id_t exp);
   if (got !== exp) begin
      $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
      stop_run();
   end
endtask

task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
   if (got !== exp) begin
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_run();
   end
endtask

// Child k of a spawn is a write task at ts + (k+1)*delta with hint + k
function automatic task_t exp_child(task_t p, int k);
   task_t       c;
   logic [31:0] delta;
   delta = {8'h00, p.args.spawn.ts_delta};
   c.ts  = p.ts;
   for (int j = 0; j <= k; j++) begin
      c.ts = c.ts + delta;
   end
   c.ttype            = TT_WRITE;
   c.hint             = p.hint + 16'(k);
   c.args.wr.addr     = p.args.spawn.child_arg + 32'(k);
   c.args.wr.old_data = p.args.spawn.child_arg;
   return c;
endfunction

// Readies of the CQ model change here and beats are logged for the next edge
task automatic cycle();
   @(negedge clk);
   start_task_ready  = next_rand_bit();
   finish_task_ready = next_rand_bit();
   task_wready       = next_rand_bit();
   undo_log_ready    = next_rand_bit();
   if (abort_seen && task_wvalid) begin
      $display("enqueue offered after the task entered ABORT_TASK at %0t", $time);
      stop_run();
   end
   if (dut0.state == ABORT_TASK) begin
      abort_seen = 1'b1;
   end
   if (task_wvalid && task_wready) begin
      got_enq.push_back(task_wdata);
      enq_beats++;
   end
   if (undo_log_valid && undo_log_ready) begin
      undo_n++;
      got_undo_id   = undo_log_id;
      got_undo_addr = undo_log_addr;
      got_undo_data = undo_log_data;
   end
   if (start_task_valid && start_task_ready) begin
      check_slot("start_task_slot", start_task_slot, cur_slot);
   end
   if (finish_task_valid && finish_task_ready) begin
      fin_seen         = 1'b1;
      got_fin_slot     = finish_task_slot;
      got_fin_children = finish_task_num_children;
      got_fin_undo     = finish_task_undo_log_write;
      got_fin_untied   = task_enq_untied;
   end
   abort_running_task = 1'b0;
   if ((abort_left > 0) && (dut0.state == WAIT_CORE)) begin
      abort_left--;
      if (abort_left == 0) begin
         abort_running_task = 1'b1;
      end
   end
endtask

task automatic write_reg(logic [7:0] addr, logic [31:0] data);
   reg_wvalid = 1'b1;
   reg_waddr  = addr;
   reg_wdata  = data;
   cycle();
   reg_wvalid = 1'b0;
endtask

task automatic read_reg(string name, logic [7:0] addr, logic [31:0] exp);
   int n;
   reg_arvalid = 1'b1;
   reg_araddr  = addr;
   cycle();
   reg_arvalid = 1'b0;
   n = 0;
   while (!reg_rvalid) begin
      cycle();
      n++;
      if (n > 10) begin
         report_timeout("reg_rvalid");
      end
   end
   check_word(name, reg_rdata, exp);
endtask

task automatic expect_no_dequeue(int cycles);
   task_rvalid = 1'b1;
   repeat (cycles) begin
      if (task_arvalid) begin
         $display("task_arvalid rose while dequeue was not allowed at %0t", $time);
         stop_run();
      end
      cycle();
   end
   task_rvalid = 1'b0;
endtask

task automatic run_row(int i);
   task_t t;
   int    n;
   t.args  = tab_args[i];
   t.ttype = tab_type[i];
   t.hint  = 16'h40 + hint_t'(i);
   t.ts    = 32'h1000 * ts_t'(i + 1);
   got_enq.delete();
   undo_n     = 0;
   fin_seen   = 1'b0;
   abort_seen = 1'b0;
   abort_left = tab_abort[i];
   cur_slot   = tab_slot[i];
   gvt_task_slot_valid = tab_gvt[i];
   gvt_task_slot       = tab_slot[i];
   task_rdata  = t;
   task_rslot  = tab_slot[i];
   task_rvalid = 1'b1;
   n = 0;
   while (!task_arvalid) begin
      cycle();
      n++;
      if (n > 50) begin
         report_timeout("task_arvalid");
      end
   end
   cycle();
   task_rvalid = 1'b0;
   n = 0;
   while (!fin_seen) begin
      cycle();
      n++;
      if (n > 500) begin
         report_timeout("finish_task handshake");
      end
   end
   gvt_task_slot_valid = 1'b0;
   check_slot("finish_task_slot", got_fin_slot, tab_slot[i]);
   check_word("finish_task_undo_log_write", 32'(got_fin_undo), 32'(tab_undo[i]));
   check_word("task_enq_untied", 32'(got_fin_untied), 32'(tab_gvt[i]));
   if (tab_abort[i] == 0) begin
      check_child("finish_task_num_children", got_fin_children, tab_nchild[i]);
   end else begin
      if (!abort_seen) begin
         $display("task of row %0d finished without entering ABORT_TASK at %0t", i, $time);
         stop_run();
      end
      // Every enqueue beat of the aborted task was still tied
      check_child("finish_task_num_children", got_fin_children,
                  child_id_t'(got_enq.size()));
   end
   if (tab_type[i] == TT_SPAWN) begin
      if (tab_abort[i] == 0) begin
         check_word("enqueue count", got_enq.size(), 32'(t.args.spawn.n_children));
      end
      for (int k = 0; k < got_enq.size(); k++) begin
         check_task("task_wdata", got_enq[k], exp_child(t, k));
      end
   end else begin
      check_word("undo record count", undo_n, 1);
      check_word("undo_log_id", 32'(got_undo_id), 32'd0);
      check_word("undo_log_addr", got_undo_addr, t.args.wr.addr);
      check_word("undo_log_data", got_undo_data, t.args.wr.old_data);
   end
endtask

initial begin
   rstn                = 1'b0;
   task_rvalid         = 1'b0;
   task_rdata          = '0;
   task_rslot          = '0;
   task_wready         = 1'b0;
   start_task_ready    = 1'b0;
   finish_task_ready   = 1'b0;
   abort_running_task  = 1'b0;
   gvt_task_slot_valid = 1'b0;
   gvt_task_slot       = '0;
   undo_log_ready      = 1'b0;
   reg_wvalid          = 1'b0;
   reg_waddr           = '0;
   reg_wdata           = '0;
   reg_arvalid         = 1'b0;
   reg_araddr          = '0;
   enq_beats           = 0;
   abort_left          = 0;
   abort_seen          = 1'b0;
   repeat (16) @(negedge clk);
   rstn = 1'b1;

   // Two dequeues allowed by the budget and none after
   write_reg(CORE_START, 32'd1 << CORE_ID);
   write_reg(CORE_N_DEQUEUES, 32'd2);
   run_row(0);
   run_row(1);
   expect_no_dequeue(20);
   read_reg("CORE_NUM_DEQ", CORE_NUM_DEQ, 32'd2);
   read_reg("CORE_NUM_ENQ", CORE_NUM_ENQ, 32'(enq_beats));
   read_reg("CORE_N_DEQUEUES", CORE_N_DEQUEUES, 32'd0);
   read_reg("CORE_TS", CORE_TS, 32'h2000);
   read_reg("CORE_STATE", CORE_STATE, 32'(NEXT_TASK));

   // Start bit cleared stops dequeue even with budget left
   write_reg(CORE_START, 32'd0);
   write_reg(CORE_N_DEQUEUES, 32'hffff_ffff);
   expect_no_dequeue(10);
   write_reg(CORE_START, 32'd1 << CORE_ID);

   for (int i = 0; i < N_ROWS; i++) begin
      run_row(i);
   end
   read_reg("CORE_NUM_ENQ", CORE_NUM_ENQ, 32'(enq_beats));

   $display("TEST PASSED");
   $finish;
end

endmodule
